//--- project.f
rtl/tile_pkg.sv
rtl/wb_if.sv
rtl/tile_bus_decoder.sv
rtl/wb_sram_sp.sv
rtl/bootrom.sv
rtl/compute_tile_dm.sv
tb/tb_clk_gen.sv
tb/tile_asserts.sv
tb/tb_compute_tile.sv

//--- run_sim.sh
#!/bin/sh
# Build the compute tile testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_compute_tile -f project.f -o tb_sim \
   && ./obj_dir/tb_sim | tee sim.log
grep -qx "=== PASS ===" sim.log && echo "Result: passed" && exit 0 \
   || { echo "Result: failed"; exit 1; }

//--- tb/tb_compute_tile.sv
//////////////////////////////////////////////////
// Compute tile testbench
// Directed tests of the local bus: data memory,
// byte lanes, boot ROM, unmapped space and
// back-to-back transfers
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_compute_tile;

   localparam int CLK_PERIOD  = 100;
   localparam int RST_CYCLES  = 8;
   localparam int LMEM_WORDS  = 1024;     // DUT defaults
   localparam int BOOT_WORDS  = 16;
   localparam int N_RAND      = 16;
   localparam int N_XFER      = 2 * N_RAND + 21;    // Transfers over all tests
   localparam int WATCHDOG_NS = 2 * (N_XFER * 4 + RST_CYCLES) * CLK_PERIOD;

   logic            clk;
   logic            rst_n;
   tile_pkg::addr_t adr;
   tile_pkg::data_t dat_w;
   tile_pkg::sel_t  sel;
   logic            we;
   logic            cyc;
   logic            stb;
   logic            ack;
   logic            err;
   tile_pkg::data_t dat_r;
   int              errors;
   int              checks;

   tb_clk_gen #(.PERIOD_NS (CLK_PERIOD)) u_clk (.clk_o (clk));

   compute_tile_dm UUT (
      .clk      (clk),
      .rst_n_i  (rst_n),
      .wb_adr_i (adr),
      .wb_dat_i (dat_w),
      .wb_sel_i (sel),
      .wb_we_i  (we),
      .wb_cyc_i (cyc),
      .wb_stb_i (stb),
      .wb_ack_o (ack),
      .wb_err_o (err),
      .wb_dat_o (dat_r)
   );

   bind compute_tile_dm tile_asserts u_asserts (
      .clk_i   (clk),
      .rst_n_i (rst_n_i),
      .cyc_i   (wb_cyc_i),
      .stb_i   (wb_stb_i),
      .ack_i   (wb_ack_o),
      .err_i   (wb_err_o)
   );

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   // Selected lanes take the new bytes
   function automatic tile_pkg::data_t merge_lanes(input tile_pkg::data_t old_w,
                                                   input tile_pkg::data_t new_w,
                                                   input tile_pkg::sel_t s);
      tile_pkg::data_t w;
      w = old_w;
      for (int b = 0; b < tile_pkg::SEL_W; b++) begin
         if (s[b]) w[b*8 +: 8] = new_w[b*8 +: 8];
      end
      return w;
   endfunction

   function automatic tile_pkg::data_t boot_word(input tile_pkg::addr_t a);
      logic [15:0] idx;
      idx = 16'(int'(a[tile_pkg::ADDR_W-1:2]) % BOOT_WORDS);
      return {tile_pkg::BOOT_TAG, idx};
   endfunction

   // Runs one transfer starting on a falling edge
   // With hold set, stb stays high into the next transfer
   task automatic access(input string name, input tile_pkg::addr_t a, input logic w,
                         input tile_pkg::sel_t s, input tile_pkg::data_t d,
                         input logic exp_err, input tile_pkg::data_t exp_rd,
                         input logic hold);
      int              waited;
      logic            got_ack;
      logic            got_err;
      tile_pkg::data_t rd;
      adr     = a;
      dat_w   = d;
      sel     = s;
      we      = w;
      cyc     = 1'b1;
      stb     = 1'b1;
      waited  = 0;
      got_ack = 1'b0;
      got_err = 1'b0;
      rd      = '0;
      while (waited < 2 && !got_ack && !got_err) begin
         @(negedge clk);
         waited++;
         got_ack = ack;
         got_err = err;
         rd      = dat_r;
      end
      if (!got_ack && !got_err) begin
         $display("%s: no ack or err within two cycles of the request", name);
         errors++;
      end else begin
         check($sformatf("%s cycles", name), 32'd1, 32'(waited));
      end
      check($sformatf("%s ack", name), 32'(!exp_err), 32'(got_ack));
      check($sformatf("%s err", name), 32'(exp_err), 32'(got_err));
      if (!w && !exp_err) check($sformatf("%s data", name), exp_rd, rd);
      @(negedge clk);                        // Request held over the response edge
      check($sformatf("%s gap", name), 32'd0, 32'({ack, err}));
      if (!hold) begin
         cyc = 1'b0;
         stb = 1'b0;
         @(negedge clk);
      end
   endtask

   task automatic dmem_random_rw();
      tile_pkg::addr_t addrs [N_RAND];
      tile_pkg::data_t model [int];
      int              idx;
      for (int i = 0; i < N_RAND; i++) begin
         addrs[i] = $urandom() & 32'h7fff_fffc;      // Word aligned with top bit 0
         idx = int'(addrs[i][tile_pkg::ADDR_W-1:2]) % LMEM_WORDS;
         model[idx] = $urandom();
         access($sformatf("dmem write %0d", i), addrs[i], 1'b1, 4'hf, model[idx],
                1'b0, '0, 1'b0);
      end
      for (int i = 0; i < N_RAND; i++) begin
         idx = int'(addrs[i][tile_pkg::ADDR_W-1:2]) % LMEM_WORDS;
         access($sformatf("dmem read %0d", i), addrs[i], 1'b0, 4'hf, '0,
                1'b0, model[idx], 1'b0);
      end
   endtask

   task automatic byte_lane_writes();
      tile_pkg::data_t exp_word;
      exp_word = 32'h1122_3344;
      access("lanes full", 32'h0000_0100, 1'b1, 4'hf, exp_word, 1'b0, '0, 1'b0);
      exp_word = merge_lanes(exp_word, 32'haabb_ccdd, 4'b0101);
      access("lanes 0 and 2", 32'h0000_0100, 1'b1, 4'b0101, 32'haabb_ccdd, 1'b0, '0, 1'b0);
      access("lanes read 1", 32'h0000_0100, 1'b0, 4'hf, '0, 1'b0, exp_word, 1'b0);
      exp_word = merge_lanes(exp_word, 32'h5566_7788, 4'b1000);
      access("lanes 3", 32'h0000_0100, 1'b1, 4'b1000, 32'h5566_7788, 1'b0, '0, 1'b0);
      access("lanes read 2", 32'h0000_0100, 1'b0, 4'hf, '0, 1'b0, exp_word, 1'b0);
   endtask

   task automatic bootrom_accesses();
      tile_pkg::addr_t list [6];
      list = '{32'hf000_0000, 32'hf000_0004, 32'hf000_003c,
               32'hf000_0040, 32'hf123_4568, 32'hffff_fffc};    // Includes index wrap
      foreach (list[i]) access($sformatf("boot read %0d", i), list[i], 1'b0, 4'hf, '0,
                               1'b0, boot_word(list[i]), 1'b0);
      access("boot write", 32'hf000_0014, 1'b1, 4'hf, 32'hdead_beef, 1'b1, '0, 1'b0);
      access("boot read after write", 32'hf000_0014, 1'b0, 4'hf, '0,
             1'b0, boot_word(32'hf000_0014), 1'b0);
   endtask

   // Nibble e was the network adapter and nibble 8 never had a slave
   task automatic unmapped_access();
      access("unmapped read e", 32'he000_0000, 1'b0, 4'hf, '0, 1'b1, '0, 1'b0);
      access("unmapped write e", 32'he000_0010, 1'b1, 4'hf, 32'h1234_5678, 1'b1, '0, 1'b0);
      access("unmapped read 8", 32'h8000_0020, 1'b0, 4'hf, '0, 1'b1, '0, 1'b0);
      access("unmapped write 8", 32'h8000_0024, 1'b1, 4'h3, 32'h0000_abcd, 1'b1, '0, 1'b0);
   endtask

   // stb stays high from the write straight into the read
   task automatic back_to_back();
      access("b2b dmem write", 32'h0000_0200, 1'b1, 4'hf, 32'hcafe_f00d, 1'b0, '0, 1'b1);
      access("b2b dmem read", 32'h0000_0200, 1'b0, 4'hf, '0, 1'b0, 32'hcafe_f00d, 1'b0);
      access("b2b unmapped write", 32'he000_0100, 1'b1, 4'hf, 32'h0bad_0bad, 1'b1, '0, 1'b1);
      access("b2b unmapped read", 32'he000_0100, 1'b0, 4'hf, '0, 1'b1, '0, 1'b0);
   endtask

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin : main
      rst_n  = 1'b0;
      adr    = '0;
      dat_w  = '0;
      sel    = '0;
      we     = 1'b0;
      cyc    = 1'b0;
      stb    = 1'b0;
      errors = 0;
      checks = 0;
      void'($urandom(12));
      repeat (RST_CYCLES) begin
         @(negedge clk);
         check("reset quiet", 32'd0, 32'({ack, err}));
      end
      rst_n = 1'b1;
      @(negedge clk);
      check("after reset", 32'd0, 32'({ack, err}));
      dmem_random_rw();
      byte_lane_writes();
      bootrom_accesses();
      unmapped_access();
      back_to_back();
      $display("Tests done: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- tb/tile_asserts.sv
//////////////////////////////////////////////////
// Local bus protocol checks
// Bound to the tile top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tile_asserts (
   input logic clk_i,
   input logic rst_n_i,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   input logic err_i
);

   a_ack_err_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(ack_i && err_i))
      else $error("ack and err are high in the same cycle");

   // A response answers the request sampled one edge earlier
   a_resp_after_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (ack_i || err_i) |-> $past(cyc_i && stb_i))
      else $error("response without a request on the previous edge");

   a_quiet_in_reset : assert property (@(posedge clk_i)
      !rst_n_i |-> !(ack_i || err_i))
      else $error("response while reset is asserted");

endmodule

//--- tb/tb_clk_gen.sv
//////////////////////////////////////////////////
// Testbench clock source
// Free-running clock, starts low
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clk_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #(PERIOD_NS / 2) clk_o = ~clk_o;    // First rising edge at half a period

endmodule

//--- rtl/compute_tile_dm.sv
//////////////////////////////////////////////////
// Distributed-memory compute tile
// Local bus with decoder, data memory and boot
// ROM behind one Wishbone master port
//////////////////////////////////////////////////

`timescale 1ns/1ns

module compute_tile_dm #(
   parameter int LMEM_WORDS = 1024,
   parameter int BOOT_WORDS = 16
) (
   input  logic            clk,
   input  logic            rst_n_i,
   input  tile_pkg::addr_t wb_adr_i,
   input  tile_pkg::data_t wb_dat_i,
   input  tile_pkg::sel_t  wb_sel_i,
   input  logic            wb_we_i,
   input  logic            wb_cyc_i,
   input  logic            wb_stb_i,
   output logic            wb_ack_o,
   output logic            wb_err_o,
   output tile_pkg::data_t wb_dat_o
);

   wb_if bus_m ();     // Master side of the decoder
   wb_if mem_s ();
   wb_if boot_s ();

   assign bus_m.adr   = wb_adr_i;
   assign bus_m.dat_w = wb_dat_i;
   assign bus_m.sel   = wb_sel_i;
   assign bus_m.we    = wb_we_i;
   assign bus_m.cyc   = wb_cyc_i;
   assign bus_m.stb   = wb_stb_i;

   assign wb_ack_o = bus_m.ack;
   assign wb_err_o = bus_m.err;
   assign wb_dat_o = bus_m.dat_r;

   tile_bus_decoder u_bus (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus_m   (bus_m),
      .mem_s   (mem_s),
      .boot_s  (boot_s)
   );

   wb_sram_sp #(
      .MEM_WORDS (LMEM_WORDS)
   ) u_ram (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus     (mem_s)
   );

   bootrom #(
      .BOOT_WORDS (BOOT_WORDS)
   ) u_bootrom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus     (boot_s)
   );

endmodule

//--- rtl/bootrom.sv
//////////////////////////////////////////////////
// Boot ROM
// Each word is the tag over its own index; writes
// are refused with an error response
//////////////////////////////////////////////////

`timescale 1ns/1ns

module bootrom #(
   parameter int BOOT_WORDS = 16
) (
   input  logic clk,
   input  logic rst_n_i,
   wb_if.slave  bus
);

   localparam int BW   = $clog2(BOOT_WORDS);
   localparam int OFFS = $clog2(tile_pkg::SEL_W);

   logic [BW-1:0] idx;
   logic          req;
   logic          ack_q;
   logic          err_q;

   assign idx = bus.adr[OFFS +: BW];    // Wraps at BOOT_WORDS

   // No response right after a response
   assign req = bus.cyc & bus.stb & ~(ack_q | err_q);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req & ~bus.we;
         err_q <= req & bus.we;          // Read-only
      end
   end

   // Address is held through the ack cycle
   assign bus.dat_r = tile_pkg::data_t'({tile_pkg::BOOT_TAG, 16'(idx)});
   assign bus.ack   = ack_q;
   assign bus.err   = err_q;

endmodule

//--- rtl/wb_sram_sp.sv
//////////////////////////////////////////////////
// Local data memory
// Single-port SRAM with byte-lane writes and a
// registered one-cycle ack
//////////////////////////////////////////////////

`timescale 1ns/1ns

module wb_sram_sp #(
   parameter int MEM_WORDS = 1024
) (
   input  logic clk,
   input  logic rst_n_i,
   wb_if.slave  bus
);

   localparam int AW   = $clog2(MEM_WORDS);
   localparam int OFFS = $clog2(tile_pkg::SEL_W);   // Byte offset bits

   tile_pkg::data_t mem [MEM_WORDS];
   logic [MEM_WORDS-1:0] written_q;    // Word has seen a write since reset
   logic [AW-1:0]        idx;
   logic                 req;
   logic                 ack_q;
   tile_pkg::data_t      dat_q;

   assign idx = bus.adr[OFFS +: AW];
   assign req = bus.cyc & bus.stb & ~ack_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q     <= 1'b0;
         written_q <= '0;
      end else begin
         ack_q <= req;
         if (req && bus.we) written_q[idx] <= 1'b1;
      end
   end

   // First write to a word clears the lanes it does not select
   always_ff @(posedge clk) begin
      if (req && bus.we) begin
         for (int b = 0; b < tile_pkg::SEL_W; b++) begin
            if (bus.sel[b]) begin
               mem[idx][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
            end else if (!written_q[idx]) begin
               mem[idx][b*8 +: 8] <= 8'h00;
            end
         end
      end
      if (req && !bus.we) dat_q <= written_q[idx] ? mem[idx] : '0;
   end

   assign bus.ack   = ack_q;
   assign bus.err   = 1'b0;    // Every access is legal
   assign bus.dat_r = dat_q;

endmodule

//--- rtl/tile_bus_decoder.sv
//////////////////////////////////////////////////
// Tile bus address decoder
// Routes the single master to the data memory or
// the boot ROM and answers unmapped addresses
// with a registered error
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tile_bus_decoder (
   input  logic clk,
   input  logic rst_n_i,
   wb_if.slave  bus_m,
   wb_if.master mem_s,
   wb_if.master boot_s
);

   logic hit_dm;
   logic hit_boot;
   logic hit_none;
   logic err_q;              // Own error response for unmapped space

   // Range match on the top address bits
   assign hit_dm   = bus_m.adr[tile_pkg::ADDR_W-1 -: tile_pkg::DM_RANGE_WIDTH]
                     == tile_pkg::DM_RANGE_MATCH;
   assign hit_boot = bus_m.adr[tile_pkg::ADDR_W-1 -: tile_pkg::BOOT_RANGE_WIDTH]
                     == tile_pkg::BOOT_RANGE_MATCH;
   assign hit_none = ~hit_dm & ~hit_boot;

   // Request fields go to both slaves, stb only to the selected one
   assign mem_s.adr   = bus_m.adr;
   assign mem_s.dat_w = bus_m.dat_w;
   assign mem_s.sel   = bus_m.sel;
   assign mem_s.we    = bus_m.we;
   assign mem_s.cyc   = bus_m.cyc;
   assign mem_s.stb   = bus_m.stb & hit_dm;

   assign boot_s.adr   = bus_m.adr;
   assign boot_s.dat_w = bus_m.dat_w;
   assign boot_s.sel   = bus_m.sel;
   assign boot_s.we    = bus_m.we;
   assign boot_s.cyc   = bus_m.cyc;
   assign boot_s.stb   = bus_m.stb & hit_boot;

   // A response never follows a response, so the held stb is not taken twice
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= bus_m.cyc & bus_m.stb & hit_none & ~err_q;
      end
   end

   // The request is held during the response cycle, so the match still holds
   always_comb begin
      if (hit_dm) begin
         bus_m.ack   = mem_s.ack;
         bus_m.err   = mem_s.err;
         bus_m.dat_r = mem_s.dat_r;
      end else if (hit_boot) begin
         bus_m.ack   = boot_s.ack;
         bus_m.err   = boot_s.err;
         bus_m.dat_r = boot_s.dat_r;
      end else begin
         bus_m.ack   = 1'b0;
         bus_m.err   = err_q;
         bus_m.dat_r = '0;    // Nothing to read in unmapped space
      end
   end

endmodule

//--- rtl/wb_if.sv
//////////////////////////////////////////////////
// Wishbone classic link
// One master and one slave, single transfer
//////////////////////////////////////////////////

`timescale 1ns/1ns

interface wb_if;

   tile_pkg::addr_t adr;
   tile_pkg::data_t dat_w;    // Write data, master to slave
   tile_pkg::sel_t  sel;
   logic            we;
   logic            cyc;
   logic            stb;
   logic            ack;
   logic            err;
   tile_pkg::data_t dat_r;    // Read data, valid with ack

   modport master (output adr, dat_w, sel, we, cyc, stb,
                   input  ack, err, dat_r);

   modport slave  (input  adr, dat_w, sel, we, cyc, stb,
                   output ack, err, dat_r);

endinterface

//--- rtl/tile_pkg.sv
//////////////////////////////////////////////////
// Compute tile shared definitions
// Bus widths, the local address map and the
// contents pattern of the boot ROM
//////////////////////////////////////////////////

package tile_pkg;

   localparam int ADDR_W = 32;             // Byte address width
   localparam int DATA_W = 32;
   localparam int SEL_W  = DATA_W / 8;     // One select per byte lane

   // Data memory owns the lower half of the map
   localparam int DM_RANGE_WIDTH = 1;
   localparam logic [DM_RANGE_WIDTH-1:0] DM_RANGE_MATCH = 1'b0;

   // Boot ROM sits in the top nibble
   localparam int BOOT_RANGE_WIDTH = 4;
   localparam logic [BOOT_RANGE_WIDTH-1:0] BOOT_RANGE_MATCH = 4'hf;

   localparam logic [15:0] BOOT_TAG = 16'hb007;  // Upper half of every ROM word

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [SEL_W-1:0]  sel_t;

endpackage
